// ==== Bender.yml ====
package:
  name: axi_id_remap

sources:
  - include_dirs:
      - common
    files:
      - common/remap_pkg.sv
      - hw/id_remap_table/id_remap_table.sv
      - hw/ax_remap_channel.sv
      - hw/axi_id_remap_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/tb_axi_id_remap.sv

// ==== common/remap_macros.svh ====
// Sizing macros for the AXI ID remapper, included by the package, the remap table and the testbench.
`ifndef REMAP_MACROS_SVH
`define REMAP_MACROS_SVH

// Slave-side IDs are wide and sparsely used, master-side IDs are narrow and dense.
`define REMAP_SLV_ID_W      8
`define REMAP_MST_ID_W      3

// Number of remap table entries, which bounds the distinct IDs in flight per direction.
`define REMAP_MAX_UNIQ_IDS  4
// Number of transactions that one slave ID may have in flight at once.
`define REMAP_MAX_TXNS      3

// Payload field widths.
`define REMAP_ADDR_W        32
`define REMAP_DATA_W        32
`define REMAP_LEN_W         8
`define REMAP_RESP_W        2

// Derived widths. The master ID width must be at least the index width.
`define REMAP_IDX_W         ($clog2(`REMAP_MAX_UNIQ_IDS))
`define REMAP_CNT_W         ($clog2(`REMAP_MAX_TXNS + 1))

`endif

// ==== common/remap_pkg.sv ====
// Shared types of the AXI ID remapper, imported by every RTL module and by the testbench.
`include "remap_macros.svh"

package remap_pkg;

  // Plain vectors for the widths that carry a meaning.
  typedef logic [`REMAP_SLV_ID_W-1:0] slv_id_t;
  typedef logic [`REMAP_MST_ID_W-1:0] mst_id_t;
  typedef logic [`REMAP_IDX_W-1:0]    idx_t;
  typedef logic [`REMAP_CNT_W-1:0]    cnt_t;
  typedef logic [`REMAP_ADDR_W-1:0]   addr_t;
  typedef logic [`REMAP_DATA_W-1:0]   data_t;
  typedef logic [`REMAP_LEN_W-1:0]    len_t;
  typedef logic [`REMAP_RESP_W-1:0]   resp_t;

  // Address request, used for both AR and AW. The len field is the beat count minus one.
  typedef struct packed {
    slv_id_t id;
    addr_t   addr;
    len_t    len;
  } ax_slv_t;

  typedef struct packed {
    mst_id_t id;
    addr_t   addr;
    len_t    len;
  } ax_mst_t;

  // Read data beat.
  typedef struct packed {
    slv_id_t id;
    data_t   data;
    resp_t   resp;
    logic    last;
  } r_slv_t;

  typedef struct packed {
    mst_id_t id;
    data_t   data;
    resp_t   resp;
    logic    last;
  } r_mst_t;

  // Write response.
  typedef struct packed {
    slv_id_t id;
    resp_t   resp;
  } b_slv_t;

  typedef struct packed {
    mst_id_t id;
    resp_t   resp;
  } b_mst_t;

  // One remap table entry. A zero counter marks the entry as free.
  typedef struct packed {
    slv_id_t id;
    cnt_t    cnt;
  } entry_t;

  // Request controller state.
  typedef enum logic {
    ST_READY,
    ST_HOLD
  } hold_state_e;

endpackage

// ==== hw/ax_remap_channel.sv ====
// Request controller for one direction: admits and remaps AR or AW requests, restores response IDs.
`timescale 1ns/100ps

module ax_remap_channel
  import remap_pkg::*;
#(
  // Set for reads, where an entry is released on the last R beat only.
  parameter bit HasLast = 1'b1
) (
  input  logic    clk_i,
  input  logic    rst_n_i,
  // Upstream request.
  input  ax_slv_t slv_ax_i,
  input  logic    slv_ax_valid_i,
  output logic    slv_ax_ready_o,
  // Downstream request.
  output ax_mst_t mst_ax_o,
  output logic    mst_ax_valid_o,
  input  logic    mst_ax_ready_i,
  // Response ID path. The rest of the response goes around this block.
  input  mst_id_t mst_rsp_id_i,
  input  logic    mst_rsp_valid_i,
  input  logic    rsp_last_i,
  input  logic    slv_rsp_ready_i,
  output slv_id_t slv_rsp_id_o
);

  hold_state_e state_q;
  hold_state_e state_d;

  // Index of a request waiting for the downstream ready.
  idx_t hold_idx_q;

  logic    tbl_free;
  idx_t    tbl_free_idx;
  logic    tbl_exists;
  idx_t    tbl_exists_idx;
  logic    tbl_exists_full;
  logic    admit;
  logic    push;
  idx_t    new_idx;
  idx_t    out_idx;
  logic    pop;

  // A known ID may go ahead while below its limit.
  // A new ID needs a free entry.
  assign admit   = tbl_exists ? !tbl_exists_full : tbl_free;
  // Reusing the index of a known ID keeps same-ID ordering downstream.
  assign new_idx = tbl_exists ? tbl_exists_idx : tbl_free_idx;

  always_comb begin
    state_d        = state_q;
    push           = 1'b0;
    out_idx        = new_idx;
    mst_ax_valid_o = 1'b0;
    slv_ax_ready_o = 1'b0;
    unique case (state_q)
      ST_READY: begin
        // The table entry is claimed in the cycle the request goes out.
        if (slv_ax_valid_i && admit) begin
          push           = 1'b1;
          mst_ax_valid_o = 1'b1;
          slv_ax_ready_o = mst_ax_ready_i;
          if (!mst_ax_ready_i) begin
            state_d = ST_HOLD;
          end
        end
      end
      ST_HOLD: begin
        // Already pushed, so only the registered index is replayed.
        out_idx        = hold_idx_q;
        mst_ax_valid_o = 1'b1;
        slv_ax_ready_o = mst_ax_ready_i;
        if (mst_ax_ready_i) begin
          state_d = ST_READY;
        end
      end
      default: begin
        state_d = ST_READY;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_READY;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push && !mst_ax_ready_i) begin
      hold_idx_q <= new_idx;
    end
  end

  // Upper master ID bits stay zero.
  assign mst_ax_o.id   = mst_id_t'(out_idx);
  assign mst_ax_o.addr = slv_ax_i.addr;
  assign mst_ax_o.len  = slv_ax_i.len;

  // Write responses release on every B, reads wait for the final beat.
  assign pop = mst_rsp_valid_i && slv_rsp_ready_i && (rsp_last_i || !HasLast);

  id_remap_table u_table (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .push_i          (push),
    .push_slv_id_i   (slv_ax_i.id),
    .push_idx_i      (new_idx),
    .free_o          (tbl_free),
    .free_idx_o      (tbl_free_idx),
    .lookup_slv_id_i (slv_ax_i.id),
    .exists_o        (tbl_exists),
    .exists_idx_o    (tbl_exists_idx),
    .exists_full_o   (tbl_exists_full),
    .pop_i           (pop),
    .pop_idx_i       (idx_t'(mst_rsp_id_i)),
    .pop_slv_id_o    (slv_rsp_id_o)
  );

  // A stalled request stays on the bus unchanged until it is taken.
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_ax_valid_o && !mst_ax_ready_i |=> mst_ax_valid_o && $stable(mst_ax_o))
    else $error("Held request dropped valid or changed its payload.");

endmodule

// ==== hw/axi_id_remap_top.sv ====
// Top level of the AXI ID remapper: one read and one write controller wired to the bus ports.
`timescale 1ns/100ps

module axi_id_remap_top
  import remap_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  // Slave side requests.
  input  ax_slv_t slv_ar_i,
  input  logic    slv_ar_valid_i,
  output logic    slv_ar_ready_o,
  input  ax_slv_t slv_aw_i,
  input  logic    slv_aw_valid_i,
  output logic    slv_aw_ready_o,
  // Slave side responses.
  output r_slv_t  slv_r_o,
  output logic    slv_r_valid_o,
  input  logic    slv_r_ready_i,
  output b_slv_t  slv_b_o,
  output logic    slv_b_valid_o,
  input  logic    slv_b_ready_i,
  // Master side requests.
  output ax_mst_t mst_ar_o,
  output logic    mst_ar_valid_o,
  input  logic    mst_ar_ready_i,
  output ax_mst_t mst_aw_o,
  output logic    mst_aw_valid_o,
  input  logic    mst_aw_ready_i,
  // Master side responses.
  input  r_mst_t  mst_r_i,
  input  logic    mst_r_valid_i,
  output logic    mst_r_ready_o,
  input  b_mst_t  mst_b_i,
  input  logic    mst_b_valid_i,
  output logic    mst_b_ready_o
);

  slv_id_t rd_slv_id;
  slv_id_t wr_slv_id;

  // Read direction. Entries are released on the last R beat.
  ax_remap_channel #(
    .HasLast (1'b1)
  ) u_rd (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .slv_ax_i        (slv_ar_i),
    .slv_ax_valid_i  (slv_ar_valid_i),
    .slv_ax_ready_o  (slv_ar_ready_o),
    .mst_ax_o        (mst_ar_o),
    .mst_ax_valid_o  (mst_ar_valid_o),
    .mst_ax_ready_i  (mst_ar_ready_i),
    .mst_rsp_id_i    (mst_r_i.id),
    .mst_rsp_valid_i (mst_r_valid_i),
    .rsp_last_i      (mst_r_i.last),
    .slv_rsp_ready_i (slv_r_ready_i),
    .slv_rsp_id_o    (rd_slv_id)
  );

  // Write direction. Every B releases its entry, so last is tied high.
  ax_remap_channel #(
    .HasLast (1'b0)
  ) u_wr (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .slv_ax_i        (slv_aw_i),
    .slv_ax_valid_i  (slv_aw_valid_i),
    .slv_ax_ready_o  (slv_aw_ready_o),
    .mst_ax_o        (mst_aw_o),
    .mst_ax_valid_o  (mst_aw_valid_o),
    .mst_ax_ready_i  (mst_aw_ready_i),
    .mst_rsp_id_i    (mst_b_i.id),
    .mst_rsp_valid_i (mst_b_valid_i),
    .rsp_last_i      (1'b1),
    .slv_rsp_ready_i (slv_b_ready_i),
    .slv_rsp_id_o    (wr_slv_id)
  );

  // Responses pass through with only the ID swapped back.
  assign slv_r_o       = '{id: rd_slv_id, data: mst_r_i.data, resp: mst_r_i.resp,
                           last: mst_r_i.last};
  assign slv_r_valid_o = mst_r_valid_i;
  assign mst_r_ready_o = slv_r_ready_i;

  assign slv_b_o       = '{id: wr_slv_id, resp: mst_b_i.resp};
  assign slv_b_valid_o = mst_b_valid_i;
  assign mst_b_ready_o = slv_b_ready_i;

endmodule

// ==== hw/id_remap_table/id_remap_table.sv ====
// Table of in-flight slave IDs for one direction, with a free-entry search and an ID lookup.
`timescale 1ns/100ps
`include "remap_macros.svh"

module id_remap_table
  import remap_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  // Allocation side, driven by the request controller.
  input  logic    push_i,
  input  slv_id_t push_slv_id_i,
  input  idx_t    push_idx_i,
  output logic    free_o,
  output idx_t    free_idx_o,
  // Lookup of the slave ID of the pending request.
  input  slv_id_t lookup_slv_id_i,
  output logic    exists_o,
  output idx_t    exists_idx_o,
  output logic    exists_full_o,
  // Release side, driven by the response path.
  input  logic    pop_i,
  input  idx_t    pop_idx_i,
  output slv_id_t pop_slv_id_o
);

  localparam int unsigned NumEntries = `REMAP_MAX_UNIQ_IDS;
  localparam cnt_t        MaxCnt     = cnt_t'(`REMAP_MAX_TXNS);

  // The table is indexed by the master-side index.
  // Each entry stores the slave ID it serves and its in-flight count.
  entry_t [NumEntries-1:0] table_q;
  entry_t [NumEntries-1:0] table_d;

  logic [NumEntries-1:0] free_vec;
  logic [NumEntries-1:0] match_vec;

  // An entry is free when nothing is in flight on it.
  // It matches when it is busy and holds the looked-up ID.
  always_comb begin
    for (int i = 0; i < NumEntries; i++) begin
      free_vec[i]  = (table_q[i].cnt == '0);
      match_vec[i] = !free_vec[i] && (table_q[i].id == lookup_slv_id_i);
    end
  end

  // Lowest free entry. The loop runs downwards so the lowest hit is the one left standing.
  always_comb begin
    free_o     = 1'b0;
    free_idx_o = '0;
    for (int i = NumEntries - 1; i >= 0; i--) begin
      if (free_vec[i]) begin
        free_o     = 1'b1;
        free_idx_o = idx_t'(i);
      end
    end
  end

  // Entry that already serves the looked-up ID.
  // At most one can match, so the scan order does not matter here.
  always_comb begin
    exists_o     = 1'b0;
    exists_idx_o = '0;
    for (int i = NumEntries - 1; i >= 0; i--) begin
      if (match_vec[i]) begin
        exists_o     = 1'b1;
        exists_idx_o = idx_t'(i);
      end
    end
  end

  // The limit flag is only meaningful together with exists_o.
  assign exists_full_o = (table_q[exists_idx_o].cnt == MaxCnt);

  // Response IDs map straight back through the stored slave ID.
  assign pop_slv_id_o = table_q[pop_idx_i].id;

  // Push and pop may hit the same entry in one cycle.
  // The pop is applied on top of the push, so the count then stays unchanged.
  always_comb begin
    table_d = table_q;
    if (push_i) begin
      table_d[push_idx_i].id  = push_slv_id_i;
      table_d[push_idx_i].cnt = table_q[push_idx_i].cnt + cnt_t'(1);
    end
    if (pop_i) begin
      table_d[pop_idx_i].cnt = table_d[pop_idx_i].cnt - cnt_t'(1);
    end
  end

  // Only the counters are cleared.
  // A stored ID is ignored while its counter is zero.
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NumEntries; i++) begin
      table_q[i].id <= table_d[i].id;
      if (!rst_n_i) begin
        table_q[i].cnt <= '0;
      end else begin
        table_q[i].cnt <= table_d[i].cnt;
      end
    end
  end

  // The controller must only release entries that have something in flight.
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> table_q[pop_idx_i].cnt != '0)
    else $error("Pop of an entry with no transaction in flight.");

  // The controller must respect the limit and must not reuse a busy entry for another ID.
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> (table_q[push_idx_i].cnt < MaxCnt) &&
               ((table_q[push_idx_i].cnt == '0) || (table_q[push_idx_i].id == push_slv_id_i)))
    else $error("Push beyond the per-ID limit or into an entry of another ID.");

  // ID independence: one slave ID never occupies two entries.
  assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(match_vec))
    else $error("Slave ID found in more than one table entry.");

endmodule

// ==== project.f ====
+incdir+common
common/remap_pkg.sv
hw/id_remap_table/id_remap_table.sv
hw/ax_remap_channel.sv
hw/axi_id_remap_top.sv
tests/tb_axi_id_remap.sv

// ==== tests/tb_axi_id_remap.sv ====
// Testbench for the AXI ID remapper: random and directed AR/AW traffic against a memory model.
`timescale 1ns/100ps
`include "remap_macros.svh"

module tb_axi_id_remap
  import remap_pkg::*;
;

  localparam int RD         = 0;
  localparam int WR         = 1;
  localparam int ReqTimeout = 1000;

  // One outstanding request as seen by the memory model.
  typedef struct packed {
    mst_id_t mid;
    slv_id_t sid;
    len_t    len;
  } job_t;

  logic    clk_i, rst_n_i;
  ax_slv_t slv_ar_i, slv_aw_i;
  logic    slv_ar_valid_i, slv_ar_ready_o, slv_aw_valid_i, slv_aw_ready_o;
  r_slv_t  slv_r_o;
  b_slv_t  slv_b_o;
  logic    slv_r_valid_o, slv_r_ready_i, slv_b_valid_o, slv_b_ready_i;
  ax_mst_t mst_ar_o, mst_aw_o;
  logic    mst_ar_valid_o, mst_ar_ready_i, mst_aw_valid_o, mst_aw_ready_i;
  r_mst_t  mst_r_i;
  b_mst_t  mst_b_i;
  logic    mst_r_valid_i, mst_r_ready_o, mst_b_valid_i, mst_b_ready_o;

  // Hold flags freeze the responses, stall flags mark a request that must not be taken.
  logic    rd_hold, wr_hold, stall_rd, stall_wr;
  job_t    rd_jobs[$];
  job_t    wr_jobs[$];
  int      cnt [2][256];
  mst_id_t mid_of [2][256];
  int      r_beat, errors, r_count, b_count;
  slv_id_t ids [6] = '{8'h03, 8'h2c, 8'h51, 8'h9e, 8'hb7, 8'hf4};

  axi_id_remap_top UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic report_error(input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic abort_run(input string what);
    $display("Timeout at %0t ns: %s", $time, what);
    $display("Simulation failed");
    $finish;
  endtask

  // Scoreboard update for one accepted request, with the mapping rules checked first.
  task automatic note_request(input int dir, input slv_id_t sid, input mst_id_t mid);
    assert (mid[`REMAP_MST_ID_W-1] == 1'b0) else report_error("upper master ID bit is set");
    assert (cnt[dir][sid] < `REMAP_MAX_TXNS) else report_error("per-ID limit was exceeded");
    if (cnt[dir][sid] > 0) begin
      assert (mid_of[dir][sid] == mid) else report_error("same slave ID got a new master ID");
    end
    for (int s = 0; s < 256; s++) begin
      if (s != sid && cnt[dir][s] > 0) begin
        assert (mid_of[dir][s] != mid) else report_error("two slave IDs share a master ID");
      end
    end
    cnt[dir][sid]++;
    mid_of[dir][sid] = mid;
  endtask

  // Presents one request and waits for the slave-side handshake.
  task automatic issue_req(input bit is_wr, input slv_id_t sid);
    ax_slv_t req;
    int      t;
    req = '{id: sid, addr: addr_t'($urandom), len: len_t'($urandom_range(3))};
    t = 0;
    @(posedge clk_i);
    if (is_wr) begin
      slv_aw_i       <= req;
      slv_aw_valid_i <= 1'b1;
    end else begin
      slv_ar_i       <= req;
      slv_ar_valid_i <= 1'b1;
    end
    do begin
      @(negedge clk_i);
      t++;
    end while (!(is_wr ? slv_aw_ready_o : slv_ar_ready_o) && t < ReqTimeout);
    if (!(is_wr ? slv_aw_ready_o : slv_ar_ready_o)) abort_run("request was never accepted");
    @(posedge clk_i);
    if (is_wr) begin
      slv_aw_valid_i <= 1'b0;
    end else begin
      slv_ar_valid_i <= 1'b0;
    end
  endtask

  // Waits until both directions have nothing outstanding.
  task automatic wait_idle();
    int t;
    t = 0;
    while ((rd_jobs.size() != 0 || wr_jobs.size() != 0) && t < ReqTimeout) begin
      @(negedge clk_i);
      t++;
    end
    if (rd_jobs.size() != 0 || wr_jobs.size() != 0) abort_run("responses did not drain");
  endtask

  // Memory model. Requests are queued and answered in arrival order.
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      mst_ar_ready_i <= 1'b0;
      mst_aw_ready_i <= 1'b0;
      mst_r_valid_i  <= 1'b0;
      mst_b_valid_i  <= 1'b0;
      r_beat = 0;
    end else begin
      if (mst_ar_valid_o && mst_ar_ready_i) begin
        assert (mst_ar_o.addr == slv_ar_i.addr && mst_ar_o.len == slv_ar_i.len)
          else report_error("AR address or length changed on the way down");
        note_request(RD, slv_ar_i.id, mst_ar_o.id);
        rd_jobs.push_back(job_t'{mid: mst_ar_o.id, sid: slv_ar_i.id, len: slv_ar_i.len});
      end
      if (mst_aw_valid_o && mst_aw_ready_i) begin
        assert (mst_aw_o.addr == slv_aw_i.addr && mst_aw_o.len == slv_aw_i.len)
          else report_error("AW address or length changed on the way down");
        note_request(WR, slv_aw_i.id, mst_aw_o.id);
        wr_jobs.push_back(job_t'{mid: mst_aw_o.id, sid: slv_aw_i.id, len: slv_aw_i.len});
      end
      mst_ar_ready_i <= ($urandom_range(3) != 0);
      mst_aw_ready_i <= ($urandom_range(3) != 0);
      slv_r_ready_i  <= ($urandom_range(3) != 0);
      slv_b_ready_i  <= ($urandom_range(3) != 0);
      // Every returned beat must carry the slave ID of the job being answered.
      if (mst_r_valid_i && mst_r_ready_o) begin
        assert (slv_r_o.id == rd_jobs[0].sid) else report_error("R beat has wrong slave ID");
        r_count++;
        if (mst_r_i.last) begin
          cnt[RD][rd_jobs[0].sid]--;
          void'(rd_jobs.pop_front());
          r_beat = 0;
          stall_rd <= 1'b0;
        end else begin
          r_beat++;
        end
      end
      if (!mst_r_valid_i || mst_r_ready_o) begin
        if (rd_jobs.size() != 0 && !rd_hold && $urandom_range(1) == 1) begin
          mst_r_i <= '{id: rd_jobs[0].mid, data: data_t'($urandom), resp: resp_t'($urandom),
                       last: (r_beat == int'(rd_jobs[0].len))};
          mst_r_valid_i <= 1'b1;
        end else begin
          mst_r_valid_i <= 1'b0;
        end
      end
      if (mst_b_valid_i && mst_b_ready_o) begin
        assert (slv_b_o.id == wr_jobs[0].sid) else report_error("B has wrong slave ID");
        b_count++;
        cnt[WR][wr_jobs[0].sid]--;
        void'(wr_jobs.pop_front());
        stall_wr <= 1'b0;
      end
      if (!mst_b_valid_i || mst_b_ready_o) begin
        if (wr_jobs.size() != 0 && !wr_hold && $urandom_range(1) == 1) begin
          mst_b_i       <= '{id: wr_jobs[0].mid, resp: resp_t'($urandom)};
          mst_b_valid_i <= 1'b1;
        end else begin
          mst_b_valid_i <= 1'b0;
        end
      end
    end
  end

  // A request is taken upstream exactly when it is taken downstream.
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (slv_ar_valid_i && slv_ar_ready_o) == (mst_ar_valid_o && mst_ar_ready_i))
    else report_error("AR handshakes on the two sides differ");
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (slv_aw_valid_i && slv_aw_ready_o) == (mst_aw_valid_o && mst_aw_ready_i))
    else report_error("AW handshakes on the two sides differ");

  // Response valid, ready and payload pass straight through apart from the ID.
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    slv_r_valid_o == mst_r_valid_i && mst_r_ready_o == slv_r_ready_i &&
    {slv_r_o.data, slv_r_o.resp, slv_r_o.last} == {mst_r_i.data, mst_r_i.resp, mst_r_i.last})
    else report_error("R channel does not pass through");
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    slv_b_valid_o == mst_b_valid_i && mst_b_ready_o == slv_b_ready_i &&
    slv_b_o.resp == mst_b_i.resp)
    else report_error("B channel does not pass through");

  // A stalled downstream request blocks upstream and stays unchanged.
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_ar_valid_o && !mst_ar_ready_i |-> !slv_ar_ready_o ##1 mst_ar_valid_o && $stable(mst_ar_o))
    else report_error("AR back-pressure violated");
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_aw_valid_o && !mst_aw_ready_i |-> !slv_aw_ready_o ##1 mst_aw_valid_o && $stable(mst_aw_o))
    else report_error("AW back-pressure violated");

  // Full table or an ID at its limit must hold the request off.
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    stall_rd && slv_ar_valid_i |-> !slv_ar_ready_o)
    else report_error("AR accepted while the read table had no room");
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    stall_wr && slv_aw_valid_i |-> !slv_aw_ready_o)
    else report_error("AW accepted while the write table had no room");

  initial begin
    void'($urandom(7));
    rst_n_i = 1'b0;
    {slv_ar_i, slv_aw_i, slv_ar_valid_i, slv_aw_valid_i} = '0;
    {slv_r_ready_i, slv_b_ready_i, mst_ar_ready_i, mst_aw_ready_i} = '0;
    {mst_r_i, mst_b_i, mst_r_valid_i, mst_b_valid_i} = '0;
    {rd_hold, wr_hold, stall_rd, stall_wr} = '0;
    {errors, r_count, b_count} = '0;
    repeat (16) @(posedge clk_i);
    rst_n_i <= 1'b1;
    // Random traffic over six IDs, more than the table holds.
    repeat (120) issue_req($urandom_range(1), ids[$urandom_range(5)]);
    wait_idle();
    // Four reads fill the read table while writes must still pass.
    rd_hold <= 1'b1;
    wr_hold <= 1'b1;
    for (int i = 0; i < 4; i++) issue_req(0, ids[i]);
    for (int i = 0; i < 4; i++) issue_req(1, ids[i]);
    stall_rd <= 1'b1;
    fork
      issue_req(0, ids[4]);
      begin
        repeat (20) @(posedge clk_i);
        rd_hold <= 1'b0;
      end
    join
    // The write table is still full and reads keep going.
    issue_req(0, ids[1]);
    stall_wr <= 1'b1;
    fork
      issue_req(1, ids[4]);
      begin
        repeat (20) @(posedge clk_i);
        wr_hold <= 1'b0;
      end
    join
    wait_idle();
    // Three reads of one ID reach the limit and a fourth has to wait.
    rd_hold <= 1'b1;
    repeat (3) issue_req(0, ids[2]);
    stall_rd <= 1'b1;
    fork
      issue_req(0, ids[2]);
      begin
        repeat (20) @(posedge clk_i);
        rd_hold <= 1'b0;
      end
    join
    wait_idle();
    $display("Run finished: %0d errors, %0d R beats, %0d B responses", errors, r_count, b_count);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
